// ==== dv/menu_mapper_stim.txt ====
# op addr data expected name; W write, R read, M prg map, P ppu fetch, C chr/ciram, T timer
# M data rw exp {ce,we,prg_addr}; C data {rd,wr} exp {oe,ciram_en,chr_we,chr_addr}; T idle clk
M 8000 1 17f8000 prg_rom_low
M fffc 1 17ffffc prg_rom_top
M 5abc 0 1fe0abc prg_ram_wr
M 7fff 0 1fe1fff prg_app_wr
M 4000 1 07fc000 prg_unmapped
W 4106 05 0 bank_wr_5
R 4106 0 05 bank_rd_5
M 6000 1 17ea000 prg_app_bank5
M 7234 0 1feb234 prg_app_bank5_wr
W 4100 34 0 vaddr_lo_wr
W 4101 12 0 vaddr_hi_wr
R 4100 0 34 vaddr_lo_rd
R 4101 0 12 vaddr_hi_rd
W 4103 32 0 attr_wr
W 4100 45 0 vaddr_lo_45
W 4101 00 0 vaddr_hi_00
W 4102 a5 0 ntb_wr_a5
W 4102 5a 0 ntb_wr_5a
R 4100 0 47 vaddr_inc_data
W 2007 00 0 ppu_data_wr
R 4100 0 48 vaddr_inc_2007
W 4100 46 0 vaddr_lo_46
R 4102 0 5a ntb_rd_5a
W 4100 45 0 vaddr_lo_45b
R 4102 0 a5 ntb_rd_a5
W 2001 08 0 render_on
P 2045 0 a5 fetch_ntb_a5
P 23c1 0 aa fetch_attr_aa
C 0123 0 07e3123 chr_menu_bank3
W 4103 a1 0 mode_saf
C 2045 2 17e3045 saf_ciram
W 4103 a2 0 mode_tst
C 2045 2 07e3045 tst_render_on
W 4103 a0 0 mode_std
C 2045 2 27e3045 std_ppu_oe
W 2001 00 0 render_off
C 2045 2 1400045 off_ciram
C 1234 1 0c01234 off_chr_we
W 4103 a2 0 mode_tst_off
C 2045 2 0400045 tst_render_off
W 4103 a0 0 mode_std_back
T 4104 0 0 timer_first
T 4104 0 0 timer_monotonic
T 4104 190 8 timer_grows

// ==== dv/menu_mapper_tb.sv ====
// menu mapper testbench with CPU and PPU bus tasks, stim-file interpreter and checks
`timescale 1ns/1ps

module menu_mapper_tb;

	localparam int TIMEOUT_CLK = 40;	// max clk spent waiting on one DUT output
	localparam int TICK_DIV    = 40;	// clk per ms in the DUT build

	logic        clk;
	logic        rst;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_rw;
	logic        cpu_m2;
	logic [7:0]  cpu_rdata;
	logic        cpu_oe;
	logic        prg_ce;
	logic        prg_we;
	logic [22:0] prg_addr;
	logic [7:0]  prg_rdata;
	logic [13:0] ppu_addr;
	logic        ppu_rd;
	logic        ppu_wr;
	logic [7:0]  ppu_rdata;
	logic        ppu_oe;
	logic        chr_ce;
	logic        chr_we;
	logic [22:0] chr_addr;
	logic        ciram_en;
	logic        ciram_a10;

	int          n_tests;
	int          n_errors;
	int          clk_count;	// clk since reset release
	logic [15:0] last_time;	// previous timer reading

	menu_mapper #(.tick_div(TICK_DIV)) i_menu_mapper (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
		if (rst)
			clk_count <= 0;
		else
			clk_count <= clk_count + 1;

	task automatic wait_clocks(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk);
	endtask

	task automatic note_pass(input string name);
		n_tests++;
		$display("ok    %s", name);
	endtask

	task automatic note_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_tests++;
		n_errors++;
		$display("Error: %s expected %h actual %h", name, expected, actual);
	endtask

	// one CPU cycle with M2 high for at least 4 clk, a write lands at the M2 fall
	task automatic cpu_cycle(input logic [15:0] addr, input logic [7:0] wdata, input logic rw,
		input string name, output logic [7:0] rdata);
		int t;
		@(negedge clk);
		cpu_addr  = addr;
		cpu_wdata = wdata;
		cpu_rw    = rw;
		cpu_m2    = 1'b1;
		t = 0;
		do
		begin
			@(negedge clk);
			t++;
		end
		while (rw && !cpu_oe && t < TIMEOUT_CLK);
		if (rw && !cpu_oe)
		begin
			n_errors++;
			$display("%s: cpu_oe did not rise during the read", name);
		end
		wait_clocks(3);
		rdata  = cpu_rdata;	// sampled while M2 is still high
		cpu_m2 = 1'b0;
		@(negedge clk);	// commit edge, address still held
	endtask

	// held until ppu_oe rises, then released so the next fetch is a fresh rise
	task automatic ppu_fetch(input logic [13:0] addr, input string name,
		output logic [7:0] rdata);
		int t;
		@(negedge clk);
		ppu_addr = addr;
		ppu_rd   = 1'b1;
		t = 0;
		do
		begin
			@(negedge clk);
			t++;
		end
		while (!ppu_oe && t < TIMEOUT_CLK);
		if (!ppu_oe)
		begin
			n_errors++;
			$display("%s: ppu_oe did not rise during the fetch", name);
		end
		rdata  = ppu_rdata;
		ppu_rd = 1'b0;
		wait_clocks(2);
	endtask

	task automatic chr_probe(input logic [13:0] addr, input logic rd, input logic wr,
		output logic [27:0] pins);
		@(negedge clk);
		ppu_addr = addr;
		ppu_rd   = rd;
		ppu_wr   = wr;
		wait_clocks(3);	// fetch pipeline is two clk deep
		pins   = {chr_ce, ciram_a10, ppu_oe, ciram_en, chr_we, chr_addr};
		ppu_rd = 1'b0;
		ppu_wr = 1'b0;
		wait_clocks(2);
	endtask

	task automatic run_line(input logic [7:0] op, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] exp, input string name);
		logic [7:0]  rdata;
		logic [7:0]  hi;
		logic [27:0] pins;
		logic [1:0]  dec_exp;
		logic [15:0] now;
		logic [15:0] floor_ms;
		logic [15:0] min_ms;
		case (op)
			"W": cpu_cycle(addr[15:0], data[7:0], 1'b0, name, rdata);
			"R":
			begin
				cpu_cycle(addr[15:0], 8'h00, 1'b1, name, rdata);
				if (rdata !== exp[7:0])
					note_mismatch(name, exp, {24'd0, rdata});
				else
					note_pass(name);
			end
			"M":
			begin
				@(negedge clk);
				cpu_addr = addr[15:0];	// M2 stays low, no commit
				cpu_rw   = data[0];
				@(negedge clk);
				if ({prg_ce, prg_we, prg_addr} !== exp[24:0])
					note_mismatch(name, exp, {7'd0, prg_ce, prg_we, prg_addr});
				else
					note_pass(name);
			end
			"P":
			begin
				ppu_fetch(addr[13:0], name, rdata);
				if (rdata !== exp[7:0])
					note_mismatch(name, exp, {24'd0, rdata});
				else
					note_pass(name);
			end
			"C":
			begin
				chr_probe(addr[13:0], data[1], data[0], pins);
				// pattern tables sit below 0x2000, CIRAM A10 is PPU A10
				dec_exp = {addr[13:0] < 14'h2000, addr[10]};
				if (pins !== {dec_exp, exp[25:0]})
					note_mismatch(name, {4'd0, dec_exp, exp[25:0]}, {4'd0, pins});
				else
					note_pass(name);
			end
			"T":
			begin
				wait_clocks(int'(data));
				floor_ms = 16'(clk_count / TICK_DIV);	// whole ms already elapsed
				cpu_cycle(addr[15:0], 8'h00, 1'b1, name, rdata);	// low byte first
				cpu_cycle(addr[15:0] + 16'd1, 8'h00, 1'b1, name, hi);
				now = {hi, rdata};
				min_ms = last_time + exp[15:0];
				if (floor_ms > min_ms)
					min_ms = floor_ms;
				if (now < min_ms)
					note_mismatch(name, {16'd0, min_ms}, {16'd0, now});
				else
					note_pass(name);
				last_time = now;
			end
			default:
			begin
				n_errors++;
				$display("unknown opcode in stim line %s", name);
			end
		endcase
	endtask

	initial
	begin
		int          fd;
		int          n_items;
		string       line;
		string       name;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;

		clk       = 1'b0;
		rst       = 1'b1;
		cpu_addr  = 16'h0000;
		cpu_wdata = 8'h00;
		cpu_rw    = 1'b1;
		cpu_m2    = 1'b0;
		prg_rdata = 8'hea;	// filler byte for PRG reads
		ppu_addr  = 14'h0000;
		ppu_rd    = 1'b0;
		ppu_wr    = 1'b0;
		n_tests   = 0;
		n_errors  = 0;
		last_time = 16'd0;
		wait_clocks(5);
		rst = 1'b0;

		fd = $fopen("dv/menu_mapper_stim.txt", "r");
		if (fd == 0)
		begin
			n_errors++;
			$display("could not open dv/menu_mapper_stim.txt");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				n_items = $sscanf(line, "%c %h %h %h %s", op, addr, data, exp, name);
				if (n_items == 5)
					run_line(op, addr, data, exp, name);	// comment lines fall through
			end
			$fclose(fd);
		end

		$display("tests run %0d, errors %0d", n_tests, n_errors);
		if (n_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the menu mapper testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module menu_mapper_tb -o menu_mapper_sim
./obj_dir/menu_mapper_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// ==== sources.f ====
src/mapper_map_pkg.sv
src/vram_pkg.sv
src/dp_ram.sv
src/cpu_decode.sv
src/ms_timer.sv
src/vram_ctrl.sv
src/ppu_render.sv
src/menu_mapper.sv
dv/menu_mapper_tb.sv

// ==== src/cpu_decode.sv ====
// CPU bus cycle end detect, area decode, PRG mapping, bank and ppu_off registers, read mux
`timescale 1ns/1ps

module cpu_decode (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_rw,
	input  logic        cpu_m2,
	input  logic [7:0]  prg_rdata,
	input  logic [7:0]  vram_rdata,
	input  logic [7:0]  timer_rdata,
	output logic [7:0]  cpu_rdata,
	output logic        cpu_oe,
	output logic        prg_ce,
	output logic        prg_we,
	output logic [22:0] prg_addr,
	output logic        bus_commit,
	output logic        ppu_data_wr,
	output logic        reg_sel_vram,
	output logic        reg_sel_timer,
	output logic        ppu_off
);

	import mapper_map_pkg::*;

	logic       m2_q;
	logic [3:0] app_bank;
	logic       reg_area, ram_area, app_area, rom_area;
	logic       bank_sel;
	logic [7:0] reg_rdata;

	always_ff @(posedge clk)
	begin
		if (rst)
			m2_q <= 1'b0;
		else
			m2_q <= cpu_m2;
	end

	assign bus_commit = m2_q & ~cpu_m2;	// end of CPU cycle

	assign reg_area = cpu_addr[15:8] == REG_PAGE;
	assign ram_area = cpu_addr[15:12] == RAM_BASE;
	assign app_area = cpu_addr[15:13] == APP_BASE;
	assign rom_area = cpu_addr[15];

	assign reg_sel_vram  = reg_area & (cpu_addr[7:2] == REG_VRAM[7:2]);
	assign reg_sel_timer = reg_area & (cpu_addr[7:1] == REG_TIMER[7:1]);
	assign bank_sel      = reg_area & (cpu_addr[7:0] == REG_APP_BANK);

	// PRG side, purely from the address
	assign prg_ce = rom_area | ram_area | app_area;
	assign prg_we = (ram_area | app_area) & ~cpu_rw;
	assign prg_addr[22:17] = PRG_SYS_BASE;
	assign prg_addr[16:0] = ram_area ? {5'd0, cpu_addr[11:0]} :
		app_area ? {app_bank, cpu_addr[12:0]} : {2'b11, cpu_addr[14:0]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			app_bank <= 4'd0;
			ppu_off  <= 1'b1;	// menu boots with rendering off
		end
		else if (bus_commit & ~cpu_rw)
		begin
			if (bank_sel)
				app_bank <= cpu_wdata[3:0];
			if (cpu_addr == PPU_MASK_ADDR)
				ppu_off <= ~cpu_wdata[3];
		end
	end

	assign ppu_data_wr = bus_commit & ~cpu_rw & (cpu_addr == PPU_DATA_ADDR);

	assign reg_rdata = bank_sel ? {4'd0, app_bank} :
		reg_sel_timer ? timer_rdata :
		reg_sel_vram ? vram_rdata : 8'h00;

	assign cpu_rdata = reg_area ? reg_rdata : prg_rdata;
	assign cpu_oe = (reg_area & cpu_rw & cpu_m2) | (prg_ce & cpu_rw);

	// a write commits the address and data held through the M2 high phase
	a_bus_stable: assert property (@(posedge clk) disable iff (rst)
		(cpu_m2 && $past(cpu_m2)) |-> $stable({cpu_addr, cpu_rw, cpu_wdata}))
		else $error("CPU bus changed while M2 was high");

endmodule

// ==== src/dp_ram.sv ====
// dual-port synchronous RAM, port A read/write, port B read-only
`timescale 1ns/1ps

module dp_ram #(
	parameter int width = 8,
	parameter int depth = 2048
) (
	input  logic                     clk,
	input  logic [$clog2(depth)-1:0] a_addr,
	input  logic [width-1:0]         a_wdata,
	input  logic                     a_we,
	output logic [width-1:0]         a_rdata,
	input  logic [$clog2(depth)-1:0] b_addr,
	output logic [width-1:0]         b_rdata
);

	logic [width-1:0] mem [depth];

	always_ff @(posedge clk)
	begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		a_rdata <= mem[a_addr];	// old data on a write cycle
	end

	always_ff @(posedge clk)
		b_rdata <= mem[b_addr];

endmodule

// ==== src/mapper_map_pkg.sv ====
// CPU address map tags, PRG and CHR bases, register page offsets, timer divider default
package mapper_map_pkg;

	// area tags compared against the top CPU address bits
	localparam logic [7:0] REG_PAGE = 8'h41;	// cpu_addr[15:8] of the register page
	localparam logic [3:0] RAM_BASE = 4'h5;	// cpu_addr[15:12], 4 KiB work RAM
	localparam logic [2:0] APP_BASE = 3'h3;	// cpu_addr[15:13], 8 KiB app window

	// PRG bits 22:17, system ROM lives at the top of the flash
	localparam logic [5:0] PRG_SYS_BASE = 6'h3F;

	// CHR bits 22:17
	localparam logic [5:0] CHR_MENU_BASE = 6'h3F;	// menu font and tiles
	localparam logic [5:0] CHR_APP_BASE  = 6'h20;	// first CHR bank, writable with ppu off

	// register page offsets (cpu_addr[7:0])
	localparam logic [7:0] REG_VRAM     = 8'd0;	// four VRAM control registers
	localparam logic [7:0] REG_TIMER    = 8'd4;	// timer low and high byte
	localparam logic [7:0] REG_APP_BANK = 8'd6;

	// console PPU registers snooped on the CPU bus
	localparam logic [15:0] PPU_MASK_ADDR = 16'h2001;	// bit 3 is background enable
	localparam logic [15:0] PPU_DATA_ADDR = 16'h2007;

	// clk cycles per millisecond at 50 MHz
	localparam int TICK_DIV_DEFAULT = 50000;

endpackage

// ==== src/menu_mapper.sv ====
// menu mapper top, CPU decode, timer, VRAM control and PPU render blocks
`timescale 1ns/1ps

module menu_mapper #(
	parameter int tick_div = mapper_map_pkg::TICK_DIV_DEFAULT
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_rw,
	input  logic        cpu_m2,
	output logic [7:0]  cpu_rdata,
	output logic        cpu_oe,
	output logic        prg_ce,
	output logic        prg_we,
	output logic [22:0] prg_addr,
	input  logic [7:0]  prg_rdata,
	input  logic [13:0] ppu_addr,
	input  logic        ppu_rd,
	input  logic        ppu_wr,
	output logic [7:0]  ppu_rdata,
	output logic        ppu_oe,
	output logic        chr_ce,
	output logic        chr_we,
	output logic [22:0] chr_addr,
	output logic        ciram_en,
	output logic        ciram_a10
);

	import vram_pkg::*;

	logic              bus_commit, ppu_data_wr;
	logic              reg_sel_vram, reg_sel_timer;
	logic              ppu_off;
	logic [7:0]        vram_rdata, timer_rdata;
	logic [7:0]        ntb_do;
	logic [ATTR_W-1:0] atr_do;
	logic [10:0]       ntb_rd_addr, atr_rd_addr;
	vram_mode_t        vram_mode;

	cpu_decode i_cpu_decode (
		.clk(clk), .rst(rst),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_rw(cpu_rw), .cpu_m2(cpu_m2),
		.prg_rdata(prg_rdata), .vram_rdata(vram_rdata), .timer_rdata(timer_rdata),
		.cpu_rdata(cpu_rdata), .cpu_oe(cpu_oe),
		.prg_ce(prg_ce), .prg_we(prg_we), .prg_addr(prg_addr),
		.bus_commit(bus_commit), .ppu_data_wr(ppu_data_wr),
		.reg_sel_vram(reg_sel_vram), .reg_sel_timer(reg_sel_timer), .ppu_off(ppu_off)
	);

	ms_timer #(.tick_div(tick_div)) i_ms_timer (
		.clk(clk), .rst(rst),
		.bus_commit(bus_commit), .reg_sel_timer(reg_sel_timer),
		.cpu_addr0(cpu_addr[0]), .cpu_rw(cpu_rw),
		.timer_rdata(timer_rdata)
	);

	vram_ctrl i_vram_ctrl (
		.clk(clk), .rst(rst),
		.cpu_addr(cpu_addr[1:0]), .cpu_wdata(cpu_wdata), .cpu_rw(cpu_rw), .cpu_m2(cpu_m2),
		.bus_commit(bus_commit), .reg_sel_vram(reg_sel_vram), .ppu_data_wr(ppu_data_wr),
		.ntb_rd_addr(ntb_rd_addr), .atr_rd_addr(atr_rd_addr),
		.vram_rdata(vram_rdata), .ntb_do(ntb_do), .atr_do(atr_do), .vram_mode(vram_mode)
	);

	ppu_render i_ppu_render (
		.clk(clk), .rst(rst),
		.ppu_addr(ppu_addr), .ppu_rd(ppu_rd), .ppu_wr(ppu_wr),
		.ppu_off(ppu_off), .vram_mode(vram_mode), .ntb_do(ntb_do), .atr_do(atr_do),
		.ntb_rd_addr(ntb_rd_addr), .atr_rd_addr(atr_rd_addr),
		.ppu_rdata(ppu_rdata), .ppu_oe(ppu_oe),
		.chr_ce(chr_ce), .chr_we(chr_we), .chr_addr(chr_addr),
		.ciram_en(ciram_en), .ciram_a10(ciram_a10)
	);

endmodule

// ==== src/ms_timer.sv ====
// millisecond counter with a high-byte snapshot taken on the low-byte read
`timescale 1ns/1ps

module ms_timer #(
	parameter int tick_div = mapper_map_pkg::TICK_DIV_DEFAULT
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       bus_commit,
	input  logic       reg_sel_timer,
	input  logic       cpu_addr0,
	input  logic       cpu_rw,
	output logic [7:0] timer_rdata
);

	localparam int DIV_W = (tick_div > 1) ? $clog2(tick_div) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [15:0]      ms_count;
	logic [7:0]       hi_snap;

	assign tick = div_cnt == DIV_W'(tick_div - 1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_cnt  <= '0;
			ms_count <= 16'd0;
			hi_snap  <= 8'd0;
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				ms_count <= ms_count + 16'd1;
			// low byte read freezes the high byte for the follow-up read
			if (bus_commit & reg_sel_timer & cpu_rw & ~cpu_addr0)
				hi_snap <= ms_count[15:8];
		end
	end

	assign timer_rdata = cpu_addr0 ? hi_snap : ms_count[7:0];

endmodule

// ==== src/ppu_render.sv ====
// two-stage PPU fetch pipeline, CHR mapping and CIRAM enable
`timescale 1ns/1ps

module ppu_render (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [13:0]                 ppu_addr,
	input  logic                        ppu_rd,
	input  logic                        ppu_wr,
	input  logic                        ppu_off,
	input  vram_pkg::vram_mode_t        vram_mode,
	input  logic [7:0]                  ntb_do,
	input  logic [vram_pkg::ATTR_W-1:0] atr_do,
	output logic [10:0]                 ntb_rd_addr,
	output logic [10:0]                 atr_rd_addr,
	output logic [7:0]                  ppu_rdata,
	output logic                        ppu_oe,
	output logic                        chr_ce,
	output logic                        chr_we,
	output logic [22:0]                 chr_addr,
	output logic                        ciram_en,
	output logic                        ciram_a10
);

	import mapper_map_pkg::*;
	import vram_pkg::*;

	logic [13:0] s1_addr;
	logic        s1_rd;
	logic        s1_atr;
	logic        s2_rd, s2_atr, s2_nt;
	logic        ntb_fetch;
	logic [1:0]  chr_bank;

	assign ntb_fetch = ppu_addr[13] & (ppu_addr[9:6] != ATR_ROW);
	assign s1_atr    = s1_addr[13] & (s1_addr[9:6] == ATR_ROW);

	// stage 1 latch, stage 2 follows the RAM read
	always_ff @(posedge clk)
	begin
		s1_addr <= ppu_addr;
		if (ppu_rd & ~s1_rd & ntb_fetch)
			atr_rd_addr <= {ppu_addr[11], ppu_addr[9:0]};	// tile index for the next attr fetch
		s2_atr <= s1_atr;
		s2_nt  <= s1_addr[13];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_rd <= 1'b0;
			s2_rd <= 1'b0;
		end
		else
		begin
			s1_rd <= ppu_rd;
			s2_rd <= s1_rd;
		end
	end

	assign ntb_rd_addr = {s1_addr[11], s1_addr[9:0]};

	// attribute byte carries the same palette for all four quadrants
	assign ppu_rdata = s2_atr ? {4{atr_do[1:0]}} : ntb_do;
	assign ppu_oe    = s2_rd & s2_nt & ~ppu_off & (vram_mode == MODE_STD);

	// pattern fetches, bank per tile while the menu renders
	assign chr_bank = ppu_off ? {1'b0, ppu_addr[12]} : atr_do[3:2];
	assign chr_ce   = ~ppu_addr[13];
	assign chr_we   = ppu_wr & ppu_off;	// CHR RAM load only with rendering off
	assign chr_addr = {ppu_off ? CHR_APP_BASE : CHR_MENU_BASE, 3'b000, chr_bank,
		ppu_addr[11:0]};

	assign ciram_a10 = ppu_addr[10];
	assign ciram_en  = (ppu_off & (vram_mode != MODE_TST)) ? ppu_addr[13] :
		(ppu_addr[13] & (vram_mode == MODE_SAF));

	// a PPU bus cycle is either a read or a write
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(ppu_rd && ppu_wr))
		else $error("ppu_rd and ppu_wr both active");

endmodule

// ==== src/vram_ctrl.sv ====
// VRAM address, data, attribute and mode registers with the CPU ports of both stores
`timescale 1ns/1ps

module vram_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [1:0]                    cpu_addr,
	input  logic [7:0]                    cpu_wdata,
	input  logic                          cpu_rw,
	input  logic                          cpu_m2,
	input  logic                          bus_commit,
	input  logic                          reg_sel_vram,
	input  logic                          ppu_data_wr,
	input  logic [10:0]                   ntb_rd_addr,
	input  logic [10:0]                   atr_rd_addr,
	output logic [7:0]                    vram_rdata,
	output logic [7:0]                    ntb_do,
	output logic [vram_pkg::ATTR_W-1:0]   atr_do,
	output vram_pkg::vram_mode_t          vram_mode
);

	import vram_pkg::*;

	logic [15:0]       vram_addr;
	logic [ATTR_W-1:0] cur_atr;	// attribute stamped on every data write
	logic              sel_lo, sel_hi, sel_data, sel_attr;
	logic              wr_commit;
	logic              ntb_we, atr_we;
	logic [7:0]        ntb_a_rdata;
	logic [ATTR_W-1:0] atr_a_rdata;

	assign sel_lo   = reg_sel_vram & (cpu_addr == VRM_ADDR_LO);
	assign sel_hi   = reg_sel_vram & (cpu_addr == VRM_ADDR_HI);
	assign sel_data = reg_sel_vram & (cpu_addr == VRM_DATA);
	assign sel_attr = reg_sel_vram & (cpu_addr == VRM_ATTR);

	assign wr_commit = bus_commit & ~cpu_rw;

	// bit 15 set lets the menu update attributes without touching names
	assign ntb_we = wr_commit & sel_data & ~vram_addr[15];
	assign atr_we = wr_commit & sel_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vram_addr <= 16'd0;
			cur_atr   <= '0;
			vram_mode <= MODE_STD;
		end
		else
		begin
			if (wr_commit & sel_lo)
				vram_addr[7:0] <= cpu_wdata;
			if (wr_commit & sel_hi)
				vram_addr[15:8] <= cpu_wdata;
			if ((wr_commit & sel_data) | ppu_data_wr)
				vram_addr <= vram_addr + 16'd1;	// auto increment
			if (bus_commit & cpu_rw & sel_data)
				cur_atr <= atr_a_rdata;	// back buffer copy
			if (wr_commit & sel_attr)
			begin
				if (cpu_wdata[7:4] == MODE_KEY)
					vram_mode <= vram_mode_t'(cpu_wdata[1:0]);
				else
					cur_atr <= {cpu_wdata[5:4], cpu_wdata[1:0]};
			end
		end
	end

	dp_ram #(
		.width(8),
		.depth(NTB_DEPTH)
	) ntb_ram (
		.clk(clk),
		.a_addr(vram_addr[10:0]),
		.a_wdata(cpu_wdata),
		.a_we(ntb_we),
		.a_rdata(ntb_a_rdata),
		.b_addr(ntb_rd_addr),
		.b_rdata(ntb_do)
	);

	dp_ram #(
		.width(ATTR_W),
		.depth(NTB_DEPTH)
	) atr_ram (
		.clk(clk),
		.a_addr(vram_addr[10:0]),
		.a_wdata(cur_atr),
		.a_we(atr_we),
		.a_rdata(atr_a_rdata),
		.b_addr(atr_rd_addr),
		.b_rdata(atr_do)
	);

	// read data only during the M2 high phase of a register read
	assign vram_rdata = ~(cpu_m2 & cpu_rw) ? 8'h00 :
		sel_lo ? vram_addr[7:0] :
		sel_hi ? vram_addr[15:8] :
		sel_data ? ntb_a_rdata : 8'h00;

	// store writes happen on the commit clk only, never spread over two cycles
	a_one_store_write: assert property (@(posedge clk) disable iff (rst)
		(ntb_we | atr_we) |=> !(ntb_we | atr_we))
		else $error("store written outside a single commit");

endmodule

// ==== src/vram_pkg.sv ====
// VRAM register offsets, vram_mode_t enum, attribute area and store size constants
package vram_pkg;

	// offsets inside the VRAM register block (cpu_addr[1:0])
	localparam logic [1:0] VRM_ADDR_LO = 2'd0;
	localparam logic [1:0] VRM_ADDR_HI = 2'd1;
	localparam logic [1:0] VRM_DATA    = 2'd2;	// nametable byte at vram_addr
	localparam logic [1:0] VRM_ATTR    = 2'd3;	// attribute or mode write

	// who owns the nametable fetches
	typedef enum logic [1:0] {
		MODE_STD = 2'd0,	// private store feeds the PPU
		MODE_SAF = 2'd1,	// CIRAM at the nametable addresses
		MODE_TST = 2'd2	// CIRAM follows the raw PPU decode
	} vram_mode_t;

	// upper nibble of an attribute write that selects the mode instead
	localparam logic [3:0] MODE_KEY = 4'hA;

	// nametable store, two screens
	localparam int NTB_DEPTH = 2048;

	// per-tile attribute: palette in 1:0, CHR bank in 3:2
	localparam int ATTR_W = 4;

	// ppu_addr[9:6] of the attribute table rows
	localparam logic [3:0] ATR_ROW = 4'b1111;

endpackage
